// File: bench/mvp_front_checker.sv
// module mvp_front_checker: reference model of the front end, compare of all DUT outputs
`timescale 1ns/1ps

module mvp_front_checker (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [95:0]  i_row_name,
    input  logic [4:0]   i_exp_err,
    input  logic         i_ap_start,
    input  logic [31:0]  i_command,
    input  logic [31:0]  i_level,
    input  logic [31:0]  i_col_size,
    input  logic [31:0]  i_split,
    input  logic [31:0]  i_index,
    input  logic [31:0]  i_mat_len,
    input  logic         i_rd_done,
    input  logic         i_wr_done,
    input  logic [31:0]  i_ap_done,
    input  logic         i_ap_ready,
    input  logic         i_ap_idle,
    input  logic         i_job_start,
    input  logic [31:0]  i_cycle_cnt,
    input  logic [31:0]  i_mat_bytes,
    input  logic [31:0]  i_vec_bytes,
    input  logic [14:0]  i_batches,
    output int           o_err_cnt
);

    // model state for the current cycle
    logic        start_prev;
    logic        pulse_prev;
    logic        rd_prev;
    logic        wr_prev;
    logic        m_busy;
    logic        m_done;
    logic [4:0]  m_err;
    logic [31:0] m_cnt;
    logic [31:0] m_mat;
    logic [31:0] m_vec;
    // flags of this row not yet compared with the table
    logic        awaiting;

    ////////////////////////////////////////////////////////////
    // rules
    ////////////////////////////////////////////////////////////

    function automatic logic [4:0] rule_errors(input logic [31:0] level,
                                               input logic [31:0] col,
                                               input logic [31:0] split,
                                               input logic [31:0] index,
                                               input logic [31:0] mat_len);
        longint row;
        logic [4:0] e;
        row  = longint'(1) << level[3:0];
        e[0] = (level == 0) || (level > 12);
        e[1] = (col == 0) || (col > 16384) || (row * longint'(col[14:0]) < 8192);
        e[2] = (split == 0) || (split > 4);
        e[3] = (index[31:13] != 0) || ($countones(index[12:0]) != 1);
        e[4] = (mat_len[31:15] != 0) ||
               (longint'(mat_len[14:0]) * longint'(index[12:0]) !=
                longint'(split[2:0]) * row);
        return e;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            o_err_cnt = o_err_cnt + 1;
            $display("mismatch %0s: %0s expected 0x%08h actual 0x%08h",
                     i_row_name, what, exp, act);
        end
    endtask

    initial o_err_cnt = 0;

    ////////////////////////////////////////////////////////////
    // per cycle compare and model step
    ////////////////////////////////////////////////////////////

    // inputs change on the rising edge, so sample on the falling one
    always @(negedge clk) begin
        logic pulse;
        logic exp_js;
        logic fin;
        logic [14:0] exp_batches;
        if (!rst_n) begin
            start_prev = 1'b0;
            pulse_prev = 1'b0;
            rd_prev    = 1'b0;
            wr_prev    = 1'b0;
            m_busy     = 1'b0;
            m_done     = 1'b0;
            m_err      = '0;
            m_cnt      = '0;
            m_mat      = '0;
            m_vec      = '0;
            awaiting   = 1'b0;
        end else begin
            pulse  = i_ap_start & ~start_prev;
            exp_js = pulse_prev & ((m_err == 0) | ~i_command[0]);
            // full job ends on write done or a bad config, read-only on read done
            if (i_command[0]) begin
                fin = (i_wr_done & ~wr_prev) | (m_err != 0);
            end else begin
                fin = i_rd_done & ~rd_prev;
            end
            exp_batches = 15'(i_mat_len[14:1]) + 15'(i_split[2:0]);

            check_value("job_start", 32'(exp_js), 32'(i_job_start));
            check_value("done", 32'(m_done), 32'(i_ap_done[0]));
            check_value("ready", 32'(m_done), 32'(i_ap_ready));
            check_value("idle", 32'(!m_busy), 32'(i_ap_idle));
            check_value("done word", {19'b0, m_err, 7'b0, m_done}, i_ap_done);
            check_value("cycle_cnt", m_cnt, i_cycle_cnt);
            check_value("mat_bytes", m_mat, i_mat_bytes);
            check_value("vec_bytes", m_vec, i_vec_bytes);
            check_value("batches", 32'(exp_batches), 32'(i_batches));
            if (awaiting && i_ap_done[0]) begin
                check_value("table errors", 32'(i_exp_err), 32'(i_ap_done[12:8]));
                awaiting = 1'b0;
            end

            // next cycle state
            if (m_busy) begin
                m_cnt = m_cnt + 1;
            end
            if (exp_js) begin
                m_busy = 1'b1;
                m_done = 1'b0;
            end else if (fin) begin
                m_busy = 1'b0;
                m_done = 1'b1;
            end
            if (pulse) begin
                m_err    = i_command[0] ? rule_errors(i_level, i_col_size, i_split,
                                                      i_index, i_mat_len) : 5'b0;
                awaiting = 1'b1;
            end
            m_mat      = i_mat_len * 32'h0001_8000;
            m_vec      = 32'(i_split[2:0]) * 32'h0003_0000;
            start_prev = i_ap_start;
            pulse_prev = pulse;
            rd_prev    = i_rd_done;
            wr_prev    = i_wr_done;
        end
    end

endmodule

// File: bench/mvp_front_props.sv
// module mvp_front_props: concurrent assertions on the host handshake, and its bind
`timescale 1ns/1ps

module mvp_front_props (
    input logic        clk,
    input logic        rst_n,
    input logic [31:0] i_command,
    input logic [31:0] o_ap_done,
    input logic        o_ap_idle,
    input logic        o_job_start
);

    // a started job goes busy next cycle
    a_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        o_job_start |=> !o_ap_idle)
        else $error("job start not followed by busy");

    // done and busy are exclusive
    a_done_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !(o_ap_done[0] && !o_ap_idle))
        else $error("done bit high while busy");

    // a flagged full job never starts
    a_gate: assert property (@(posedge clk) disable iff (!rst_n)
        !(o_job_start && (o_ap_done[12:8] != 5'b0) && i_command[0]))
        else $error("job start with config errors");

endmodule

bind mvp_front_top mvp_front_props props_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_command   (i_command),
    .o_ap_done   (o_ap_done),
    .o_ap_idle   (o_ap_idle),
    .o_job_start (o_job_start)
);

// File: bench/tb_mvp_front.sv
// module tb_mvp_front: clock, reset, job table, stimulus loop, lfsr delays, timeout
`timescale 1ns/1ps

module tb_mvp_front;

    typedef struct packed {
        logic [95:0] name;
        logic [31:0] command;
        logic [31:0] level;
        logic [31:0] col_size;
        logic [31:0] split;
        logic [31:0] index;
        logic [31:0] mat_len;
        logic        use_wr;
        logic [4:0]  exp_err;
    } row_t;

    localparam int NUM_ROWS    = 10;
    localparam int RESET_CYC   = 10;
    localparam int CYCLE_LIMIT = 40 * NUM_ROWS + RESET_CYC;

    logic        clk;
    logic        rst_n;
    logic        ap_start;
    logic [31:0] command;
    logic [31:0] level;
    logic [31:0] col_size;
    logic [31:0] split;
    logic [31:0] index;
    logic [31:0] mat_len;
    logic        rd_done;
    logic        wr_done;
    logic [31:0] ap_done;
    logic        ap_ready;
    logic        ap_idle;
    logic        job_start;
    logic [31:0] cycle_cnt;
    logic [31:0] mat_bytes;
    logic [31:0] vec_bytes;
    logic [14:0] batches;
    logic [95:0] row_name;
    logic [4:0]  exp_err;
    int          err_cnt;
    int          timeouts;
    int          cycles;
    logic [15:0] lfsr;
    row_t        rows [NUM_ROWS];

    mvp_front_top #(.CYCLE_CNT_WIDTH(32)) dut_i (
        .clk (clk), .rst_n (rst_n), .i_ap_start (ap_start), .i_command (command),
        .i_level (level), .i_col_size (col_size), .i_split (split), .i_index (index),
        .i_mat_len (mat_len), .i_rd_done (rd_done), .i_wr_done (wr_done),
        .o_ap_done (ap_done), .o_ap_ready (ap_ready), .o_ap_idle (ap_idle),
        .o_job_start (job_start), .o_cycle_cnt (cycle_cnt), .o_mat_bytes (mat_bytes),
        .o_vec_bytes (vec_bytes), .o_batches (batches)
    );

    mvp_front_checker chk_i (
        .clk (clk), .rst_n (rst_n), .i_row_name (row_name), .i_exp_err (exp_err),
        .i_ap_start (ap_start), .i_command (command), .i_level (level),
        .i_col_size (col_size), .i_split (split), .i_index (index), .i_mat_len (mat_len),
        .i_rd_done (rd_done), .i_wr_done (wr_done), .i_ap_done (ap_done),
        .i_ap_ready (ap_ready), .i_ap_idle (ap_idle), .i_job_start (job_start),
        .i_cycle_cnt (cycle_cnt), .i_mat_bytes (mat_bytes), .i_vec_bytes (vec_bytes),
        .i_batches (batches), .o_err_cnt (err_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // 2..17 cycles with one lfsr step per bit
    task automatic draw_delay(output int d);
        d = 0;
        for (int b = 0; b < 4; b++) begin
            lfsr = lfsr_next(lfsr);
            d    = (d << 1) | int'(lfsr[0]);
        end
        d = d + 2;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // stops at the next rising edge after the signal is seen high
    task automatic wait_job_start();
        do @(negedge clk); while (!job_start);
        @(posedge clk);
    endtask

    task automatic wait_done();
        do @(negedge clk); while (!ap_done[0]);
        @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // job table
    ////////////////////////////////////////////////////////////

    // first row is rejected while done is still low after reset
    initial begin
        //          name           cmd  level   col    split  index     mat_len   wr err
        rows[0] = '{"bad_level",   1, 0,      8192,  2,     1,        2,        1, 5'h01};
        rows[1] = '{"valid_l12",   1, 12,     2,     4,     4,        4096,     1, 5'h00};
        rows[2] = '{"read_only",   0, 0,      0,     0,     0,        0,        0, 5'h00};
        rows[3] = '{"valid_l1",    1, 1,      4096,  2,     1,        4,        1, 5'h00};
        rows[4] = '{"bad_col",     1, 1,      100,   2,     1,        4,        1, 5'h02};
        rows[5] = '{"bad_split",   1, 1,      4096,  5,     2,        5,        1, 5'h04};
        rows[6] = '{"bad_index",   1, 1,      4096,  2,     32'h2001, 4,        1, 5'h08};
        rows[7] = '{"bad_mat_len", 1, 1,      4096,  2,     1,        5,        1, 5'h10};
        rows[8] = '{"multi_bad",   1, 32'h20, 0,     0,     0,        32'h8000, 1, 5'h1f};
        rows[9] = '{"read_only_b", 2, 7,      0,     9,     3,        1,        0, 5'h00};
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        int delay;
        lfsr     = 16'd62;
        timeouts = 0;
        rst_n    <= 1'b0;
        ap_start <= 1'b0;
        command  <= '0;
        level    <= '0;
        col_size <= '0;
        split    <= '0;
        index    <= '0;
        mat_len  <= '0;
        rd_done  <= 1'b0;
        wr_done  <= 1'b0;
        row_name <= "reset";
        exp_err  <= '0;
        wait_cycles(RESET_CYC);
        rst_n <= 1'b1;
        wait_cycles(2);

        for (int r = 0; r < NUM_ROWS; r++) begin
            row_name <= rows[r].name;
            exp_err  <= rows[r].exp_err;
            command  <= rows[r].command;
            level    <= rows[r].level;
            col_size <= rows[r].col_size;
            split    <= rows[r].split;
            index    <= rows[r].index;
            mat_len  <= rows[r].mat_len;
            wait_cycles(2);
            ap_start <= 1'b1;
            if (!rows[r].command[0] || rows[r].exp_err == 0) begin
                wait_job_start();
                // the unselected done input must be ignored
                if (rows[r].use_wr) rd_done <= 1'b1;
                else wr_done <= 1'b1;
                draw_delay(delay);
                wait_cycles(delay);
                if (rows[r].use_wr) wr_done <= 1'b1;
                else rd_done <= 1'b1;
                wait_done();
            end else begin
                // rejected jobs finish two cycles after the start pulse
                wait_cycles(4);
            end
            ap_start <= 1'b0;
            rd_done  <= 1'b0;
            wr_done  <= 1'b0;
            wait_cycles(3);
        end

        $display("closing: %0d mismatches, %0d timeouts", err_cnt, timeouts);
        if (err_cnt == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        timeouts = timeouts + 1;
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("closing: %0d mismatches, %0d timeouts", err_cnt, timeouts);
        $display("Test failed");
        $finish;
    end

endmodule

// File: list.f
logic/mvp_pkg.sv
logic/mvp_cfg_check.sv
logic/mvp_ap_ctrl.sv
logic/mvp_xfer_size.sv
logic/mvp_front_top.sv
bench/mvp_front_props.sv
bench/mvp_front_checker.sv
bench/tb_mvp_front.sv

// File: logic/mvp_ap_ctrl.sv
// module mvp_ap_ctrl: start edge, job start gating, done/idle handshake, busy cycle counter
`timescale 1ns/1ps

module mvp_ap_ctrl #(
    parameter int CYCLE_CNT_WIDTH = 32
) (
    input  logic                       clk,
    input  logic                       rst_n,
    // host start level
    input  logic                       i_ap_start,
    input  mvp_pkg::cfg_word_t         i_command,
    input  mvp_pkg::cfg_err_t          i_cfg_err,
    // datapath finish levels
    input  logic                       i_rd_done,
    input  logic                       i_wr_done,
    output logic                       o_start_pulse,
    output logic                       o_job_start,
    output logic                       o_done,
    output logic                       o_idle,
    output logic [CYCLE_CNT_WIDTH-1:0] o_cycle_cnt
);

    import mvp_pkg::*;

    logic                       start_q;
    // start pulse delayed to line up with the error flags
    logic                       start_pulse_q;
    logic                       rd_done_q;
    logic                       wr_done_q;
    logic                       rd_rise;
    logic                       wr_rise;
    // end of job, or immediate end on a rejected config
    logic                       finish;
    logic                       done_q;
    ap_state_t                  state_q;
    logic [CYCLE_CNT_WIDTH-1:0] cycle_cnt_q;

    //////////////////////////////////////////////////////////////
    // edge detection
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q       <= 1'b0;
            start_pulse_q <= 1'b0;
            rd_done_q     <= 1'b0;
            wr_done_q     <= 1'b0;
        end else begin
            start_q       <= i_ap_start;
            start_pulse_q <= o_start_pulse;
            rd_done_q     <= i_rd_done;
            wr_done_q     <= i_wr_done;
        end
    end

    // first cycle of start high after low
    assign o_start_pulse = i_ap_start & ~start_q;
    assign rd_rise       = i_rd_done & ~rd_done_q;
    assign wr_rise       = i_wr_done & ~wr_done_q;

    // flags are valid one cycle after the start edge
    // bad config only blocks full jobs (command[0] set)
    assign o_job_start = start_pulse_q & ((i_cfg_err == '0) | ~i_command[0]);

    // full job ends on write done, read-only job on read done
    assign finish = i_command[0] ? (wr_rise | (i_cfg_err != '0)) : rd_rise;

    //////////////////////////////////////////////////////////////
    // handshake state
    //////////////////////////////////////////////////////////////

    // job start wins over a finish in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= AP_IDLE;
            done_q  <= 1'b0;
        end else if (o_job_start) begin
            state_q <= AP_BUSY;
            done_q  <= 1'b0;
        end else if (finish) begin
            state_q <= AP_IDLE;
            done_q  <= 1'b1;
        end
    end

    assign o_done = done_q;
    assign o_idle = (state_q == AP_IDLE);

    // busy cycles since reset, wraps
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt_q <= '0;
        end else if (state_q == AP_BUSY) begin
            cycle_cnt_q <= cycle_cnt_q + 1'b1;
        end
    end

    assign o_cycle_cnt = cycle_cnt_q;

endmodule

// File: logic/mvp_cfg_check.sv
// module mvp_cfg_check: five job config checks and their sticky error flags
`timescale 1ns/1ps

module mvp_cfg_check (
    input  logic              clk,
    input  logic              rst_n,
    // one cycle pulse on the host start edge
    input  logic              i_start_pulse,
    input  mvp_pkg::cfg_word_t i_command,
    input  mvp_pkg::cfg_word_t i_level,
    input  mvp_pkg::cfg_word_t i_col_size,
    input  mvp_pkg::cfg_word_t i_split,
    input  mvp_pkg::cfg_word_t i_index,
    input  mvp_pkg::cfg_word_t i_mat_len,
    output mvp_pkg::cfg_err_t  o_cfg_err
);

    import mvp_pkg::*;

    // 2^level[3:0], up to 2^15
    logic [15:0] row_size;
    // row_size * col_size[14:0]
    logic [31:0] mat_coeffs;
    // mat_len[14:0] * index[12:0]
    logic [31:0] len_by_index;
    // split[2:0] * row_size
    logic [31:0] split_by_row;
    // set bits in the legal index field
    logic [3:0]  index_ones;
    // raw check results, same bit order as cfg_err_t
    cfg_err_t    chk_fail;
    cfg_err_t    cfg_err_q;

    //////////////////////////////////////////////////////////////
    // derived quantities
    //////////////////////////////////////////////////////////////

    assign row_size     = 16'd1 << i_level[3:0];
    assign mat_coeffs   = 32'(row_size) * 32'(i_col_size[14:0]);
    assign len_by_index = 32'(i_mat_len[MAT_LEN_BITS-1:0]) * 32'(i_index[INDEX_BITS-1:0]);
    assign split_by_row = 32'(i_split[2:0]) * 32'(row_size);
    assign index_ones   = 4'($countones(i_index[INDEX_BITS-1:0]));

    //////////////////////////////////////////////////////////////
    // the five checks, 1 means error
    //////////////////////////////////////////////////////////////

    // level out of range
    assign chk_fail[0] = (i_level == '0) || (i_level > MAX_LEVEL);

    // col_size zero, too big, or matrix too small for this level
    assign chk_fail[1] = (i_col_size == '0) ||
                         (i_col_size > MAX_COL_SIZE) ||
                         (mat_coeffs < MIN_MAT_COEFFS);

    // split 1..4 only
    assign chk_fail[2] = (i_split == '0) || (i_split > MAX_SPLIT);

    // index must be one-hot within its low field
    assign chk_fail[3] = (i_index[31:INDEX_BITS] != '0) || (index_ones != 4'd1);

    // mat_len fits its field and matches split * row_size / index
    assign chk_fail[4] = (i_mat_len[31:MAT_LEN_BITS] != '0) ||
                         (len_by_index != split_by_row);

    //////////////////////////////////////////////////////////////
    // sticky flags
    //////////////////////////////////////////////////////////////

    // sampled once per job on the start edge
    // read-only jobs (command[0] clear) are never flagged
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_err_q <= '0;
        end else if (i_start_pulse) begin
            if (i_command[0]) begin
                cfg_err_q <= chk_fail;
            end else begin
                cfg_err_q <= '0;
            end
        end
    end

    // flags hold until the next start edge
    assign o_cfg_err = cfg_err_q;

endmodule

// File: logic/mvp_front_top.sv
// module mvp_front_top: job front end top, control, config check, transfer sizing, done word
`timescale 1ns/1ps

module mvp_front_top #(
    parameter int CYCLE_CNT_WIDTH = 32
) (
    input  logic                       clk,
    input  logic                       rst_n,
    // host control
    input  logic                       i_ap_start,
    input  mvp_pkg::cfg_word_t         i_command,
    input  mvp_pkg::cfg_word_t         i_level,
    input  mvp_pkg::cfg_word_t         i_col_size,
    input  mvp_pkg::cfg_word_t         i_split,
    input  mvp_pkg::cfg_word_t         i_index,
    input  mvp_pkg::cfg_word_t         i_mat_len,
    // datapath finish levels
    input  logic                       i_rd_done,
    input  logic                       i_wr_done,
    // host status
    output mvp_pkg::cfg_word_t         o_ap_done,
    output logic                       o_ap_ready,
    output logic                       o_ap_idle,
    // to the datapath
    output logic                       o_job_start,
    output logic [CYCLE_CNT_WIDTH-1:0] o_cycle_cnt,
    output mvp_pkg::xfer_bytes_t       o_mat_bytes,
    output mvp_pkg::xfer_bytes_t       o_vec_bytes,
    output mvp_pkg::batch_cnt_t        o_batches
);

    import mvp_pkg::*;

    logic     w_start_pulse;
    cfg_err_t w_cfg_err;
    logic     w_done;

    //////////////////////////////////////////////////////////////
    // handshake and busy counter
    //////////////////////////////////////////////////////////////

    mvp_ap_ctrl #(
        .CYCLE_CNT_WIDTH (CYCLE_CNT_WIDTH)
    ) ap_ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_ap_start    (i_ap_start),
        .i_command     (i_command),
        .i_cfg_err     (w_cfg_err),
        .i_rd_done     (i_rd_done),
        .i_wr_done     (i_wr_done),
        .o_start_pulse (w_start_pulse),
        .o_job_start   (o_job_start),
        .o_done        (w_done),
        .o_idle        (o_ap_idle),
        .o_cycle_cnt   (o_cycle_cnt)
    );

    // config flags, sampled on the start edge
    mvp_cfg_check cfg_check_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_start_pulse (w_start_pulse),
        .i_command     (i_command),
        .i_level       (i_level),
        .i_col_size    (i_col_size),
        .i_split       (i_split),
        .i_index       (i_index),
        .i_mat_len     (i_mat_len),
        .o_cfg_err     (w_cfg_err)
    );

    // sizes for the axi engines
    mvp_xfer_size xfer_size_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_mat_len   (i_mat_len),
        .i_split     (i_split),
        .o_mat_bytes (o_mat_bytes),
        .o_vec_bytes (o_vec_bytes),
        .o_batches   (o_batches)
    );

    //////////////////////////////////////////////////////////////
    // host status word
    //////////////////////////////////////////////////////////////

    // done in bit 0, error flags in 12:8
    assign o_ap_done  = {19'b0, w_cfg_err, 7'b0, w_done};
    assign o_ap_ready = w_done;

endmodule

// File: logic/mvp_pkg.sv
// package: config word, byte count, batch count and error vector types, limits, ap state enum
package mvp_pkg;

    //////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////

    // one host config word (command, level, col_size, ...)
    typedef logic [31:0] cfg_word_t;

    // byte count handed to the axi engines
    typedef logic [31:0] xfer_bytes_t;

    // number of data batches
    typedef logic [14:0] batch_cnt_t;

    // sticky config errors
    // bit 0 level, 1 col_size, 2 split, 3 index, 4 mat_len
    typedef logic [4:0] cfg_err_t;

    // host handshake state
    typedef enum logic {
        AP_IDLE = 1'b0,
        AP_BUSY = 1'b1
    } ap_state_t;

    //////////////////////////////////////////////////////////////
    // config limits
    //////////////////////////////////////////////////////////////

    localparam cfg_word_t MAX_LEVEL      = 32'd12;
    localparam cfg_word_t MAX_COL_SIZE   = 32'd16384;
    // smallest row_size * col_size
    localparam cfg_word_t MIN_MAT_COEFFS = 32'd8192;
    localparam cfg_word_t MAX_SPLIT      = 32'd4;

    // index may only be nonzero below this bit
    localparam int INDEX_BITS   = 13;
    // same for mat_len
    localparam int MAT_LEN_BITS = 15;

    //////////////////////////////////////////////////////////////
    // transfer sizing
    //////////////////////////////////////////////////////////////

    // bytes of matrix per unit of mat_len
    localparam xfer_bytes_t MAT_BYTES_PER_LEN   = 32'h0001_8000;
    // bytes of vector per split
    localparam xfer_bytes_t VEC_BYTES_PER_SPLIT = 32'h0003_0000;

endpackage

// File: logic/mvp_xfer_size.sv
// module mvp_xfer_size: matrix and vector byte sizes and the batch count
`timescale 1ns/1ps

module mvp_xfer_size (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mvp_pkg::cfg_word_t   i_mat_len,
    input  mvp_pkg::cfg_word_t   i_split,
    output mvp_pkg::xfer_bytes_t o_mat_bytes,
    output mvp_pkg::xfer_bytes_t o_vec_bytes,
    output mvp_pkg::batch_cnt_t  o_batches
);

    import mvp_pkg::*;

    xfer_bytes_t mat_bytes_q;
    xfer_bytes_t vec_bytes_q;

    //////////////////////////////////////////////////////////////
    // byte sizes
    //////////////////////////////////////////////////////////////

    // registered, the multipliers sit right before the flops
    // products keep only the low 32 bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mat_bytes_q <= '0;
            vec_bytes_q <= '0;
        end else begin
            mat_bytes_q <= i_mat_len * MAT_BYTES_PER_LEN;
            vec_bytes_q <= xfer_bytes_t'(i_split[2:0]) * VEC_BYTES_PER_SPLIT;
        end
    end

    assign o_mat_bytes = mat_bytes_q;
    assign o_vec_bytes = vec_bytes_q;

    //////////////////////////////////////////////////////////////
    // batch count
    //////////////////////////////////////////////////////////////

    // half the matrix length plus one batch per split
    assign o_batches = batch_cnt_t'(i_mat_len[14:1]) + batch_cnt_t'(i_split[2:0]);

endmodule

// File: run.sh
#!/bin/sh
# build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module tb_mvp_front -f list.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" sim.log; then
    exit 0
fi
exit 1
